// ==== common/oram_settings.svh ====
/*
 Widths and sizes for the block core, the funnels and the test logic
*/
`ifndef ORAM_SETTINGS_SVH
`define ORAM_SETTINGS_SVH

// ------------------------------
// Data path
// ------------------------------

// Block and back-end data width
`define BLOCK_WIDTH 64

// External DRAM data bus
`define NET_WIDTH 16

// Block address, also DRAMAddress
`define ADDR_WIDTH 10

// One write-mask bit per byte
`define MASK_WIDTH (`BLOCK_WIDTH / 8)

// ------------------------------
// Test logic
// ------------------------------

// Blocks written and verified by the traffic generator
`define TGEN_BLOCKS 16

// Captured status word
`define STATUS_WIDTH 32

`endif

// ==== common/oramPkg.sv ====
/*
 Shared enums: user and DRAM commands, core and traffic generator states
*/
package oramPkg;

	// ------------------------------
	// Commands
	// ------------------------------

	// User block command
	typedef enum logic {
		CmdWrite = 1'b0,
		CmdRead = 1'b1
	} oramCmdE;

	// Command toward the DRAM back end
	typedef enum logic {
		DramWrite = 1'b0,
		DramRead = 1'b1
	} dramCmdE;

	// ------------------------------
	// State machines
	// ------------------------------

	// Block core, one command in flight
	typedef enum logic [2:0] {
		Idle,
		// masked write fetches the old block first
		ReadOld,
		WaitOld,
		IssueWrite,
		SendData,
		IssueRead,
		WaitRead,
		Respond
	} coreStateE;

	// Write-then-verify generator
	typedef enum logic [1:0] {
		TgCmd,
		TgData,
		TgWait,
		TgDone
	} trafficStateE;

endpackage

// ==== logic/widthFunnel.sv ====
/*
 Shift-register width converter, gathers or splits, lowest piece first
*/
`timescale 1ns/1ps

module widthFunnel #(
	parameter int InWidth = 16,
	parameter int OutWidth = 64
) (
	input logic Clock,
	input logic rstN,
	input logic [InWidth-1:0] inData,
	input logic inValid,
	output logic inReady,
	output logic [OutWidth-1:0] outData,
	output logic outValid,
	input logic outReady
);

	localparam int WideWidth = (InWidth > OutWidth) ? InWidth : OutWidth;
	localparam int NarrowWidth = (InWidth > OutWidth) ? OutWidth : InWidth;
	localparam int Ratio = WideWidth / NarrowWidth;
	localparam int CntWidth = (Ratio > 1) ? $clog2(Ratio) : 1;

	logic [WideWidth-1:0] buffer;
	logic [CntWidth-1:0] pieceCount;
	logic full;
	logic lastPiece;
	logic inFire;
	logic outFire;

	// Buffer holds one wide word
	assign inReady = !full;
	assign outValid = full;
	assign inFire = inValid && inReady;
	assign outFire = outValid && outReady;
	assign lastPiece = pieceCount == CntWidth'(Ratio - 1);

	if (WideWidth % NarrowWidth != 0) begin : gBadRatio
		$error("widthFunnel: widths %0d and %0d are not multiples", InWidth, OutWidth);
	end

	if (OutWidth > InWidth) begin : gGather
		// ------------------------------
		// Narrow in, wide out
		// ------------------------------
		assign outData = buffer;

		always_ff @(posedge Clock or negedge rstN) begin
			if (!rstN) begin
				full <= 1'b0;
				pieceCount <= '0;
			end else if (inFire) begin
				full <= lastPiece;
				pieceCount <= lastPiece ? '0 : pieceCount + 1'b1;
			end else if (outFire) begin
				full <= 1'b0;
			end
		end

		// New piece enters at the top, first one ends lowest
		always_ff @(posedge Clock) begin
			if (inFire) buffer <= {inData, buffer[WideWidth-1:InWidth]};
		end
	end else begin : gSplit
		// ------------------------------
		// Wide in, narrow out
		// ------------------------------
		assign outData = buffer[OutWidth-1:0];

		always_ff @(posedge Clock or negedge rstN) begin
			if (!rstN) begin
				full <= 1'b0;
				pieceCount <= '0;
			end else if (inFire) begin
				full <= 1'b1;
				pieceCount <= '0;
			end else if (outFire) begin
				pieceCount <= pieceCount + 1'b1;
				if (lastPiece) full <= 1'b0;
			end
		end

		always_ff @(posedge Clock) begin
			if (inFire) buffer <= inData;
			else if (outFire) buffer <= buffer >> OutWidth;
		end
	end

endmodule

// ==== logic/dummyGen.sv ====
/*
 Dummy DRAM responder: LFSR data for each read, served read count
*/
`timescale 1ns/1ps
`include "oram_settings.svh"

module dummyGen (
	input logic Clock,
	input logic rstN,
	input logic commandValid,
	output logic commandReady,
	output logic [`BLOCK_WIDTH-1:0] readData,
	output logic readDataValid,
	output logic [15:0] readCount
);

	logic pending;
	logic stageQ;
	logic accept;
	logic [63:0] lfsr;
	logic feedback;

	assign commandReady = !pending;
	assign accept = commandValid && commandReady;
	// x^64 + x^63 + x^61 + x^60 + 1
	assign feedback = lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59];

	// One read in flight, answered two cycles after accept
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pending <= 1'b0;
			stageQ <= 1'b0;
			readDataValid <= 1'b0;
			readCount <= '0;
			lfsr <= 64'h5EED_C0DE_1357_9BDF;
		end else begin
			stageQ <= accept;
			readDataValid <= stageQ;
			if (accept) pending <= 1'b1;
			else if (readDataValid) pending <= 1'b0;
			if (stageQ) lfsr <= {lfsr[62:0], feedback};
			if (readDataValid && readCount != 16'hFFFF) readCount <= readCount + 1'b1;
		end
	end

	always_ff @(posedge Clock) begin
		if (stageQ) readData <= `BLOCK_WIDTH'(lfsr);
	end

	// No second command before the first is answered
	onePending: assert property (@(posedge Clock) disable iff (!rstN)
		accept |=> (!commandReady until_with readDataValid));

endmodule

// ==== logic/trafficGen.sv ====
/*
 On-chip traffic generator: writes a fixed block set, reads it back, counts mismatches
*/
`timescale 1ns/1ps
`include "oram_settings.svh"

module trafficGen
	import oramPkg::*;
(
	input logic Clock,
	input logic rstN,
	output oramCmdE cmd,
	output logic [`ADDR_WIDTH-1:0] pAddr,
	output logic cmdValid,
	input logic cmdReady,
	output logic [`BLOCK_WIDTH-1:0] dataIn,
	output logic dataInValid,
	input logic dataInReady,
	input logic [`BLOCK_WIDTH-1:0] dataOut,
	input logic dataOutValid,
	output logic dataOutReady,
	output logic done,
	output logic [7:0] errorCount
);

	trafficStateE state;
	logic readPhase;
	logic [`ADDR_WIDTH-1:0] addrQ;
	logic [15:0] patternWord;
	logic lastAddr;

	// Block a holds a ^ A5C3, four copies
	assign patternWord = 16'(addrQ) ^ 16'hA5C3;
	assign lastAddr = addrQ == `ADDR_WIDTH'(`TGEN_BLOCKS - 1);

	assign cmd = readPhase ? CmdRead : CmdWrite;
	assign pAddr = addrQ;
	assign cmdValid = state == TgCmd;
	assign dataIn = {(`BLOCK_WIDTH / 16){patternWord}};
	assign dataInValid = state == TgData;
	assign dataOutReady = state == TgWait;
	assign done = state == TgDone;

	// ------------------------------
	// Write phase, then read phase
	// ------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= TgCmd;
			readPhase <= 1'b0;
			addrQ <= '0;
			errorCount <= '0;
		end else begin
			unique case (state)
				TgCmd: if (cmdReady) state <= readPhase ? TgWait : TgData;
				TgData: begin
					if (dataInReady) begin
						state <= TgCmd;
						// Wrap to address 0 for the reads
						if (lastAddr) begin
							readPhase <= 1'b1;
							addrQ <= '0;
						end else begin
							addrQ <= addrQ + 1'b1;
						end
					end
				end
				TgWait: begin
					if (dataOutValid) begin
						// Saturating mismatch count
						if (dataOut != dataIn && errorCount != 8'hFF) errorCount <= errorCount + 1'b1;
						if (lastAddr) begin
							state <= TgDone;
						end else begin
							addrQ <= addrQ + 1'b1;
							state <= TgCmd;
						end
					end
				end
				TgDone: state <= TgDone;
				default: state <= TgCmd;
			endcase
		end
	end

endmodule

// ==== blockCore/blockCore.sv ====
/*
 Plain block store: user block commands to DRAM commands,
 partial masks done as read, merge and write back
*/
`timescale 1ns/1ps
`include "oram_settings.svh"

module blockCore
	import oramPkg::*;
(
	input logic Clock,
	input logic rstN,
	// User command port
	input oramCmdE cmd,
	input logic [`ADDR_WIDTH-1:0] pAddr,
	input logic [`MASK_WIDTH-1:0] wMask,
	input logic cmdValid,
	output logic cmdReady,
	// User data ports
	input logic [`BLOCK_WIDTH-1:0] dataIn,
	input logic dataInValid,
	output logic dataInReady,
	output logic [`BLOCK_WIDTH-1:0] dataOut,
	output logic dataOutValid,
	input logic dataOutReady,
	// Back end, one block per beat
	output logic [`ADDR_WIDTH-1:0] dramAddress,
	output dramCmdE dramCommand,
	output logic dramCommandValid,
	input logic dramCommandReady,
	input logic [`BLOCK_WIDTH-1:0] dramReadData,
	input logic dramReadDataValid,
	output logic [`BLOCK_WIDTH-1:0] dramWriteData,
	output logic dramWriteDataValid,
	input logic dramWriteDataReady,
	input logic dummyMode
);

	coreStateE state;
	logic cmdReadyQ;
	logic gotData;
	logic [`ADDR_WIDTH-1:0] dummyAddr;
	logic [`ADDR_WIDTH-1:0] addrQ;
	logic [`MASK_WIDTH-1:0] maskQ;
	logic [`BLOCK_WIDTH-1:0] newData;
	logic [`BLOCK_WIDTH-1:0] blockQ;
	logic [`BLOCK_WIDTH-1:0] merged;
	logic cmdFire;
	logic dataFire;
	logic dummyNext;

	assign cmdFire = cmdValid && cmdReady;
	assign dataFire = dataInValid && dataInReady;
	// Next dummy read, at start and after each returned block
	assign dummyNext = dummyMode && (state == Idle || (state == WaitRead && dramReadDataValid));

	// ------------------------------
	// Outputs from state
	// ------------------------------

	assign cmdReady = cmdReadyQ;
	// New block accepted while the old one is fetched
	assign dataInReady = (state == ReadOld || state == WaitOld || state == IssueWrite) && !gotData;
	assign dramCommandValid = state == ReadOld || state == IssueRead ||
		(state == IssueWrite && gotData);
	assign dramCommand = (state == IssueWrite) ? DramWrite : DramRead;
	assign dramAddress = addrQ;
	assign dramWriteData = merged;
	assign dramWriteDataValid = state == SendData;
	assign dataOut = blockQ;
	assign dataOutValid = state == Respond;

	// Byte merge, mask bit set takes the new byte
	always_comb begin
		for (int i = 0; i < `MASK_WIDTH; i++) begin
			merged[8*i +: 8] = maskQ[i] ? newData[8*i +: 8] : blockQ[8*i +: 8];
		end
	end

	// ------------------------------
	// Control FSM
	// ------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= Idle;
			cmdReadyQ <= 1'b0;
			gotData <= 1'b0;
			dummyAddr <= '0;
		end else begin
			if (dataFire) gotData <= 1'b1;
			if (dummyNext) dummyAddr <= dummyAddr + 1'b1;
			unique case (state)
				Idle: begin
					if (dummyMode) begin
						cmdReadyQ <= 1'b0;
						state <= IssueRead;
					end else if (cmdFire) begin
						cmdReadyQ <= 1'b0;
						gotData <= 1'b0;
						if (cmd == CmdRead) state <= IssueRead;
						else if (&wMask) state <= IssueWrite;
						else state <= ReadOld;
					end else begin
						cmdReadyQ <= 1'b1;
					end
				end
				ReadOld: if (dramCommandReady) state <= WaitOld;
				WaitOld: if (dramReadDataValid) state <= IssueWrite;
				IssueWrite: if (dramCommandValid && dramCommandReady) state <= SendData;
				SendData: if (dramWriteDataReady) state <= Idle;
				IssueRead: if (dramCommandReady) state <= WaitRead;
				WaitRead: begin
					// Dummy reads run back to back
					if (dramReadDataValid) state <= dummyMode ? IssueRead : Respond;
				end
				Respond: if (dataOutReady) state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	// Address, mask and block payload
	always_ff @(posedge Clock) begin
		if (cmdFire) begin
			addrQ <= pAddr;
			maskQ <= wMask;
		end else if (dummyNext) begin
			addrQ <= dummyAddr;
		end
		if (dataFire) newData <= dataIn;
		if (dramReadDataValid && (state == WaitOld || state == WaitRead)) blockQ <= dramReadData;
	end

	// DRAM command and address hold until taken
	dramCmdHeld: assert property (@(posedge Clock) disable iff (!rstN)
		dramCommandValid && !dramCommandReady |=>
			dramCommandValid && $stable(dramAddress) && $stable(dramCommand));

	// Registered ready only ever seen in Idle
	cmdReadyIdle: assert property (@(posedge Clock) disable iff (!rstN)
		cmdReady |-> state == Idle);

endmodule

// ==== logic/oramTestWrap.sv ====
/*
 Tapeout test wrapper: mode steering, block core, traffic and dummy generators,
 DRAM width funnels and status capture
*/
`timescale 1ns/1ps
`include "oram_settings.svh"

module oramTestWrap
	import oramPkg::*;
(
	input logic Clock,
	input logic rstN,
	// User port
	input oramCmdE Cmd,
	input logic [`ADDR_WIDTH-1:0] PAddr,
	input logic [`MASK_WIDTH-1:0] WMask,
	input logic CmdValid,
	output logic CmdReady,
	input logic [`BLOCK_WIDTH-1:0] DataIn,
	input logic DataInValid,
	output logic DataInReady,
	output logic [`BLOCK_WIDTH-1:0] DataOut,
	output logic DataOutValid,
	input logic DataOutReady,
	// External DRAM port
	output logic [`ADDR_WIDTH-1:0] DRAMAddress,
	output dramCmdE DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [`NET_WIDTH-1:0] DRAMReadData,
	input logic DRAMReadDataValid,
	output logic [`NET_WIDTH-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady,
	// Mode pins and status readout
	input logic modeTrafficGen,
	input logic modeDummyGen,
	input logic statusReq,
	output logic [`STATUS_WIDTH-1:0] statusWord
);

	logic trafficMode;
	logic dummyMode;
	oramCmdE coreCmd;
	logic [`ADDR_WIDTH-1:0] corePAddr;
	logic [`MASK_WIDTH-1:0] coreWMask;
	logic coreCmdValid;
	logic coreCmdReady;
	logic [`BLOCK_WIDTH-1:0] coreDataIn;
	logic coreDataInValid;
	logic coreDataInReady;
	logic [`BLOCK_WIDTH-1:0] coreDataOut;
	logic coreDataOutValid;
	logic coreDataOutReady;
	dramCmdE coreDramCommand;
	logic coreDramCommandValid;
	logic coreDramCommandReady;
	logic [`BLOCK_WIDTH-1:0] coreReadData;
	logic coreReadDataValid;
	logic [`BLOCK_WIDTH-1:0] coreWriteData;
	logic coreWriteDataValid;
	logic coreWriteDataReady;
	oramCmdE tgCmd;
	logic [`ADDR_WIDTH-1:0] tgPAddr;
	logic tgCmdValid;
	logic [`BLOCK_WIDTH-1:0] tgDataIn;
	logic tgDataInValid;
	logic tgDataOutReady;
	logic tgDone;
	logic [7:0] tgErrorCount;
	logic dgenCommandValid;
	logic dgenCommandReady;
	logic [`BLOCK_WIDTH-1:0] dgenReadData;
	logic dgenReadDataValid;
	logic [15:0] dgenReadCount;
	logic [`BLOCK_WIDTH-1:0] netReadData;
	logic netReadDataValid;
	logic netWriteReady;

	// Mode pins only count while in reset; both high means dummy mode
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			trafficMode <= modeTrafficGen && !modeDummyGen;
			dummyMode <= modeDummyGen;
		end
	end

	// ------------------------------
	// User side steering
	// ------------------------------

	assign coreCmd = trafficMode ? tgCmd : Cmd;
	assign corePAddr = trafficMode ? tgPAddr : PAddr;
	assign coreWMask = trafficMode ? '1 : WMask;
	assign coreCmdValid = (trafficMode ? tgCmdValid : CmdValid) && !dummyMode;
	assign CmdReady = coreCmdReady && !trafficMode && !dummyMode;
	assign coreDataIn = trafficMode ? tgDataIn : DataIn;
	assign coreDataInValid = (trafficMode ? tgDataInValid : DataInValid) && !dummyMode;
	assign DataInReady = coreDataInReady && !trafficMode && !dummyMode;
	assign DataOut = coreDataOut;
	assign DataOutValid = coreDataOutValid && !trafficMode && !dummyMode;
	assign coreDataOutReady = trafficMode ? tgDataOutReady : DataOutReady;

	trafficGen i_trafficGen (
		.Clock(Clock), .rstN(rstN),
		.cmd(tgCmd), .pAddr(tgPAddr), .cmdValid(tgCmdValid),
		.cmdReady(coreCmdReady && trafficMode),
		.dataIn(tgDataIn), .dataInValid(tgDataInValid),
		.dataInReady(coreDataInReady && trafficMode),
		.dataOut(coreDataOut), .dataOutValid(coreDataOutValid && trafficMode),
		.dataOutReady(tgDataOutReady), .done(tgDone), .errorCount(tgErrorCount)
	);

	blockCore i_core (
		.Clock(Clock), .rstN(rstN),
		.cmd(coreCmd), .pAddr(corePAddr), .wMask(coreWMask),
		.cmdValid(coreCmdValid), .cmdReady(coreCmdReady),
		.dataIn(coreDataIn), .dataInValid(coreDataInValid), .dataInReady(coreDataInReady),
		.dataOut(coreDataOut), .dataOutValid(coreDataOutValid), .dataOutReady(coreDataOutReady),
		.dramAddress(DRAMAddress), .dramCommand(coreDramCommand),
		.dramCommandValid(coreDramCommandValid), .dramCommandReady(coreDramCommandReady),
		.dramReadData(coreReadData), .dramReadDataValid(coreReadDataValid),
		.dramWriteData(coreWriteData), .dramWriteDataValid(coreWriteDataValid),
		.dramWriteDataReady(coreWriteDataReady), .dummyMode(dummyMode)
	);

	// ------------------------------
	// DRAM side steering
	// ------------------------------

	assign DRAMCommand = coreDramCommand;
	assign DRAMCommandValid = coreDramCommandValid && !dummyMode;
	assign dgenCommandValid = coreDramCommandValid && dummyMode && coreDramCommand == DramRead;
	assign coreDramCommandReady = dummyMode ? dgenCommandReady : DRAMCommandReady;
	assign coreReadData = dummyMode ? dgenReadData : netReadData;
	assign coreReadDataValid = dummyMode ? dgenReadDataValid : netReadDataValid;
	// Dummy mode swallows core write data here
	assign coreWriteDataReady = dummyMode ? 1'b1 : netWriteReady;

	dummyGen i_dummyGen (
		.Clock(Clock), .rstN(rstN),
		.commandValid(dgenCommandValid), .commandReady(dgenCommandReady),
		.readData(dgenReadData), .readDataValid(dgenReadDataValid),
		.readCount(dgenReadCount)
	);

	// Four 16-bit beats gathered into one block
	widthFunnel #(.InWidth(`NET_WIDTH), .OutWidth(`BLOCK_WIDTH)) i_readFunnel (
		.Clock(Clock), .rstN(rstN),
		.inData(DRAMReadData), .inValid(DRAMReadDataValid), .inReady(),
		.outData(netReadData), .outValid(netReadDataValid), .outReady(1'b1)
	);

	widthFunnel #(.InWidth(`BLOCK_WIDTH), .OutWidth(`NET_WIDTH)) i_writeFunnel (
		.Clock(Clock), .rstN(rstN),
		.inData(coreWriteData), .inValid(coreWriteDataValid && !dummyMode),
		.inReady(netWriteReady),
		.outData(DRAMWriteData), .outValid(DRAMWriteDataValid), .outReady(DRAMWriteDataReady)
	);

	// Status: done, error count, zero byte, dummy read count
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) statusWord <= '0;
		else if (statusReq) statusWord <= {tgDone, tgErrorCount[6:0], 8'h00, dgenReadCount};
	end

endmodule

// ==== bench/oramTestWrapTb.sv ====
/*
 Testbench for the tapeout wrapper: clock, reset, 16-bit DRAM model,
 pattern-driven user tests, traffic and dummy mode checks
*/
`timescale 1ns/1ps
`include "oram_settings.svh"

module oramTestWrapTb
	import oramPkg::*;
();

	localparam int BeatsPerBlock = `BLOCK_WIDTH / `NET_WIDTH;
	localparam int CyclesPerLine = 200;
	localparam int ModeCycles = 4000;

	logic Clock;
	logic rstN;
	oramCmdE Cmd;
	logic [`ADDR_WIDTH-1:0] PAddr;
	logic [`MASK_WIDTH-1:0] WMask;
	logic CmdValid;
	logic CmdReady;
	logic [`BLOCK_WIDTH-1:0] DataIn;
	logic DataInValid;
	logic DataInReady;
	logic [`BLOCK_WIDTH-1:0] DataOut;
	logic DataOutValid;
	logic DataOutReady;
	logic [`ADDR_WIDTH-1:0] DRAMAddress;
	dramCmdE DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady;
	logic [`NET_WIDTH-1:0] DRAMReadData;
	logic DRAMReadDataValid;
	logic [`NET_WIDTH-1:0] DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady;
	logic modeTrafficGen;
	logic modeDummyGen;
	logic statusReq;
	logic [`STATUS_WIDTH-1:0] statusWord;

	// Pattern table, one entry per file line
	string opList[$];
	logic [`ADDR_WIDTH-1:0] addrList[$];
	logic [`MASK_WIDTH-1:0] maskList[$];
	logic [`BLOCK_WIDTH-1:0] dataList[$];
	logic [`BLOCK_WIDTH-1:0] expList[$];

	// DRAM model state
	logic [`BLOCK_WIDTH-1:0] modelMem [0:(1 << `ADDR_WIDTH)-1];
	logic [`ADDR_WIDTH-1:0] writeAddrQ[$];
	logic [`BLOCK_WIDTH-1:0] readBlock;
	logic [`BLOCK_WIDTH-1:0] gatherBlock;
	logic [`ADDR_WIDTH-1:0] lastCmdAddr;
	int readBeatsLeft;
	int writeBeat;

	bit stallOn;
	bit trafficCheck;
	bit dummyCheck;
	bit holdSeen;
	logic [`BLOCK_WIDTH-1:0] heldData;
	int failCount;
	int cycleCount;
	int cycleLimit;

	oramTestWrap i_dut (.*);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	// ------------------------------
	// Checks and helpers
	// ------------------------------

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			failCount++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic checkCondition(input string what, input bit ok);
		assert (ok) else begin
			failCount++;
			$display("Error: %s", what);
			$display("** FAIL **");
			$fatal(1, "check failed");
		end
	endtask

	// Ready draw, 1 in 4 stalls when enabled
	function automatic bit randomReady();
		return !stallOn || ($urandom_range(3) != 0);
	endfunction

	// Hung run guard
	always @(posedge Clock) begin
		cycleCount++;
		checkCondition($sformatf("run passed its limit of %0d cycles", cycleLimit),
			cycleCount < cycleLimit);
	end

	// ------------------------------
	// 16-bit DRAM model
	// ------------------------------

	// Sample on the edge, update and drive 1 ns later
	always @(posedge Clock) begin : dramModel
		bit cmdFire;
		bit isRead;
		bit beatFire;
		logic [`ADDR_WIDTH-1:0] cmdAddr;
		logic [`NET_WIDTH-1:0] beat;
		cmdFire = rstN && DRAMCommandValid && DRAMCommandReady;
		isRead = DRAMCommand == DramRead;
		cmdAddr = DRAMAddress;
		beatFire = rstN && DRAMWriteDataValid && DRAMWriteDataReady;
		beat = DRAMWriteData;
		#1;
		if (!rstN) begin
			writeAddrQ.delete();
			readBeatsLeft = 0;
			writeBeat = 0;
		end
		if (cmdFire) begin
			lastCmdAddr = cmdAddr;
			if (isRead) begin
				readBlock = modelMem[cmdAddr];
				readBeatsLeft = BeatsPerBlock;
			end else begin
				writeAddrQ.push_back(cmdAddr);
			end
		end
		if (beatFire) begin
			checkCondition("write data beat without a write command", writeAddrQ.size() != 0);
			gatherBlock[`NET_WIDTH*writeBeat +: `NET_WIDTH] = beat;
			writeBeat++;
			// Last beat lands the whole block
			if (writeBeat == BeatsPerBlock) begin
				modelMem[writeAddrQ.pop_front()] = gatherBlock;
				writeBeat = 0;
			end
		end
		// Lowest beat first
		if (readBeatsLeft > 0) begin
			DRAMReadData = readBlock[`NET_WIDTH*(BeatsPerBlock-readBeatsLeft) +: `NET_WIDTH];
			DRAMReadDataValid = 1'b1;
			readBeatsLeft--;
		end else begin
			DRAMReadDataValid = 1'b0;
		end
		// No new command while a block is still in flight
		DRAMCommandReady = randomReady() && writeAddrQ.size() == 0 && readBeatsLeft == 0;
		DRAMWriteDataReady = randomReady();
	end

	// ------------------------------
	// Monitors
	// ------------------------------

	// DataOut held while stalled
	always @(posedge Clock) begin
		if (rstN && holdSeen) begin
			checkCondition("DataOutValid dropped while DataOutReady was low", DataOutValid);
			checkValue("DataOut hold", heldData, DataOut);
		end
		holdSeen = rstN && DataOutValid && !DataOutReady;
		heldData = DataOut;
	end

	always @(posedge Clock) begin
		if (trafficCheck)
			checkCondition("user handshake active in traffic mode",
				!CmdReady && !DataInReady && !DataOutValid);
		if (dummyCheck)
			checkCondition("external DRAM or user command traffic in dummy mode",
				!DRAMCommandValid && !DRAMWriteDataValid && !CmdReady);
	end

	// ------------------------------
	// Stimulus tasks
	// ------------------------------

	task automatic loadPatterns();
		int fd;
		int fields;
		string lineText;
		string opText;
		logic [`ADDR_WIDTH-1:0] addr;
		logic [`MASK_WIDTH-1:0] mask;
		logic [`BLOCK_WIDTH-1:0] data;
		logic [`BLOCK_WIDTH-1:0] expected;
		fd = $fopen("bench/wrapPatterns.txt", "r");
		checkCondition("cannot open bench/wrapPatterns.txt", fd != 0);
		while (!$feof(fd)) begin
			lineText = "";
			void'($fgets(lineText, fd));
			// Skip comments and blank lines
			if (lineText.len() > 1 && lineText[0] != "#") begin
				fields = $sscanf(lineText, "%s %h %h %h %h", opText, addr, mask, data, expected);
				checkCondition({"pattern line unreadable: ", lineText},
					fields == 5 && (opText == "W" || opText == "R"));
				opList.push_back(opText);
				addrList.push_back(addr);
				maskList.push_back(mask);
				dataList.push_back(data);
				expList.push_back(expected);
			end
		end
		$fclose(fd);
		checkCondition("pattern file holds no operations", opList.size() > 0);
		// Table runs twice, quiet and stalled
		cycleLimit = CyclesPerLine * 2 * opList.size() + ModeCycles;
	endtask

	task automatic applyReset(input bit traffic, input bit dummy);
		@(posedge Clock);
		#1;
		rstN = 1'b0;
		modeTrafficGen = traffic;
		modeDummyGen = dummy;
		CmdValid = 1'b0;
		DataInValid = 1'b0;
		DataOutReady = 1'b0;
		statusReq = 1'b0;
		repeat (5) @(posedge Clock);
		checkValue("outputs in reset", '0, {DRAMCommandValid, DRAMWriteDataValid,
			DataOutValid, CmdReady, DataInReady, statusWord});
		#1;
		rstN = 1'b1;
	endtask

	task automatic writeUserBlock(input logic [`ADDR_WIDTH-1:0] addr,
		input logic [`MASK_WIDTH-1:0] mask, input logic [`BLOCK_WIDTH-1:0] data);
		@(posedge Clock);
		#1;
		Cmd = CmdWrite;
		PAddr = addr;
		WMask = mask;
		CmdValid = 1'b1;
		do @(posedge Clock); while (!CmdReady);
		#1;
		CmdValid = 1'b0;
		DataIn = data;
		DataInValid = 1'b1;
		do @(posedge Clock); while (!DataInReady);
		#1;
		DataInValid = 1'b0;
		// Done at the next CmdReady, block lands after its last beat
		do @(posedge Clock); while (!CmdReady || writeAddrQ.size() != 0);
	endtask

	task automatic readUserBlock(input logic [`ADDR_WIDTH-1:0] addr,
		output logic [`BLOCK_WIDTH-1:0] data);
		bit got;
		@(posedge Clock);
		#1;
		Cmd = CmdRead;
		PAddr = addr;
		CmdValid = 1'b1;
		do @(posedge Clock); while (!CmdReady);
		#1;
		CmdValid = 1'b0;
		DataOutReady = randomReady();
		got = 1'b0;
		while (!got) begin
			@(posedge Clock);
			if (DataOutValid && DataOutReady) begin
				data = DataOut;
				got = 1'b1;
			end else begin
				#1;
				DataOutReady = randomReady();
			end
		end
		#1;
		DataOutReady = 1'b0;
	endtask

	task automatic runPattern(input int idx);
		string name;
		logic [`BLOCK_WIDTH-1:0] got;
		name = $sformatf("%s %03h entry %0d%s", opList[idx], addrList[idx], idx + 1,
			stallOn ? " stalled" : "");
		if (opList[idx] == "W") begin
			writeUserBlock(addrList[idx], maskList[idx], dataList[idx]);
		end else begin
			readUserBlock(addrList[idx], got);
			checkValue({name, " DataOut"}, expList[idx], got);
		end
		// Cross-check against the model memory
		checkValue({name, " memory"}, expList[idx], modelMem[addrList[idx]]);
		checkValue({name, " DRAMAddress"}, 64'(addrList[idx]), 64'(lastCmdAddr));
	endtask

	task automatic captureStatus(output logic [`STATUS_WIDTH-1:0] word);
		@(posedge Clock);
		#1;
		statusReq = 1'b1;
		@(posedge Clock);
		#1;
		statusReq = 1'b0;
		@(posedge Clock);
		word = statusWord;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial begin : mainFlow
		logic [`STATUS_WIDTH-1:0] firstStatus;
		logic [`STATUS_WIDTH-1:0] secondStatus;
		logic [15:0] word;
		void'($urandom(32'hdb5f4099));
		rstN = 1'b0;
		Cmd = CmdWrite;
		PAddr = '0;
		WMask = '0;
		CmdValid = 1'b0;
		DataIn = '0;
		DataInValid = 1'b0;
		DataOutReady = 1'b0;
		DRAMCommandReady = 1'b0;
		DRAMReadData = '0;
		DRAMReadDataValid = 1'b0;
		DRAMWriteDataReady = 1'b0;
		modeTrafficGen = 1'b0;
		modeDummyGen = 1'b0;
		statusReq = 1'b0;
		stallOn = 1'b0;
		trafficCheck = 1'b0;
		dummyCheck = 1'b0;
		holdSeen = 1'b0;
		failCount = 0;
		cycleCount = 0;
		cycleLimit = ModeCycles;
		readBeatsLeft = 0;
		writeBeat = 0;
		lastCmdAddr = '0;
		for (int a = 0; a < (1 << `ADDR_WIDTH); a++) modelMem[a] = {4{16'(a) ^ 16'h5A3C}};
		loadPatterns();

		// User mode, quiet DRAM first, then random stalls
		applyReset(1'b0, 1'b0);
		for (int i = 0; i < opList.size(); i++) runPattern(i);
		stallOn = 1'b1;
		for (int i = 0; i < opList.size(); i++) runPattern(i);

		// Traffic mode, status polled every cycle
		applyReset(1'b1, 1'b0);
		trafficCheck = 1'b1;
		statusReq = 1'b1;
		do @(posedge Clock); while (!statusWord[31]);
		checkValue("traffic error field", '0, statusWord[30:24]);
		checkValue("traffic zero byte", '0, statusWord[23:16]);
		#1;
		statusReq = 1'b0;
		trafficCheck = 1'b0;
		// Block a holds a ^ A5C3 four times
		for (int a = 0; a < `TGEN_BLOCKS; a++) begin
			word = 16'(a) ^ 16'hA5C3;
			checkValue($sformatf("traffic block %0d", a), {4{word}}, modelMem[a]);
		end

		// Dummy mode, captures 100 cycles apart
		applyReset(1'b0, 1'b1);
		dummyCheck = 1'b1;
		repeat (30) @(posedge Clock);
		captureStatus(firstStatus);
		repeat (97) @(posedge Clock);
		captureStatus(secondStatus);
		dummyCheck = 1'b0;
		checkCondition("dummy read count is zero", firstStatus[15:0] != 0);
		checkCondition("dummy read count did not increase",
			secondStatus[15:0] > firstStatus[15:0]);
		checkValue("dummy status upper half", '0, secondStatus[31:16]);

		if (failCount == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("** FAIL **");
			$fatal(1, "checks failed");
		end
	end

endmodule

// ==== bench/wrapPatterns.txt ====
# op addr mask data expected, all hex; W writes data under the byte mask
# W expects the merged block in memory, R expects it on DataOut (data column unused)
W 010 FF 0123456789ABCDEF 0123456789ABCDEF
R 010 FF 0000000000000000 0123456789ABCDEF
W 011 FF FEDCBA9876543210 FEDCBA9876543210
W 3FF FF DEADBEEFCAFEF00D DEADBEEFCAFEF00D
R 011 FF 0000000000000000 FEDCBA9876543210
R 3FF FF 0000000000000000 DEADBEEFCAFEF00D
W 010 0F 1111111111111111 0123456711111111
R 010 FF 0000000000000000 0123456711111111
W 011 F0 AAAAAAAAAAAAAAAA AAAAAAAA76543210
R 011 FF 0000000000000000 AAAAAAAA76543210
W 3FF 81 0000000000000000 00ADBEEFCAFEF000
R 3FF FF 0000000000000000 00ADBEEFCAFEF000
W 010 55 FFFFFFFFFFFFFFFF 01FF45FF11FF11FF
R 010 FF 0000000000000000 01FF45FF11FF11FF
W 200 FF 0F0F0F0F0F0F0F0F 0F0F0F0F0F0F0F0F
W 200 00 FFFFFFFFFFFFFFFF 0F0F0F0F0F0F0F0F
R 200 FF 0000000000000000 0F0F0F0F0F0F0F0F
W 200 3C 123456789ABCDEF0 0F0F56789ABC0F0F
R 200 FF 0000000000000000 0F0F56789ABC0F0F
R 011 FF 0000000000000000 AAAAAAAA76543210

// ==== filelist.f ====
+incdir+common
common/oramPkg.sv
logic/widthFunnel.sv
logic/dummyGen.sv
logic/trafficGen.sv
blockCore/blockCore.sv
logic/oramTestWrap.sv
bench/oramTestWrapTb.sv

// ==== Bender.yml ====
package:
  name: oram_test_wrap

sources:
  - include_dirs:
      - common
    files:
      - common/oramPkg.sv
      - logic/widthFunnel.sv
      - logic/dummyGen.sv
      - logic/trafficGen.sv
      - blockCore/blockCore.sv
      - logic/oramTestWrap.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/oramTestWrapTb.sv
